// ==== dv/fetch_stimulus.txt ====
# load <word index, decimal> <64-bit data, hex> | jump <target, hex> <cycles with fetch on first>
# run <fetch count>, then that many lines of: expect <pc, hex> <instr, hex>
load 0 0050009300000013
load 1 0020823300a00113
load 2 0040a02340110333
load 3 00c000ef0000a283
load 8 0030839300100313
load 9 fe0008e30073f463
load 16 000000730ff0000f
load 17 00b5053312345537
run 5
expect 0000000080000000 00000013
expect 0000000080000004 00500093
expect 0000000080000008 00a00113
expect 000000008000000c 00208233
expect 0000000080000010 40110333
jump 0000000080000040 3
run 3
expect 0000000080000040 00100313
expect 0000000080000044 00308393
expect 0000000080000048 0073f463
jump 0000000080000084 0
run 2
expect 0000000080000084 00000073
expect 0000000080000088 12345537
load 0 deadc0b77ff00513
jump 0000000080000000 0
run 2
expect 0000000080000000 7ff00513
expect 0000000080000004 deadc0b7
jump 0000000080000010 2
run 3
expect 0000000080000010 40110333
expect 0000000080000014 0040a023
expect 0000000080000018 0000a283
# address past the ram depth folds back onto word 0
jump 0000000080000204 0
run 1
expect 0000000080000204 deadc0b7

// ==== dv/tb_clkgen.sv ====
module tb_clkgen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 2
) (
  output logic clk_o,
  output logic arst_n_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // free running clock, low at time zero
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2);
      clk_o = ~clk_o;
    end
  end

  // release lands on a falling edge, away from the sampling edge
  initial begin
    arst_n_o = 1'b0;
    #(PERIOD_NS * RESET_CYCLES);
    arst_n_o = 1'b1;
  end

endmodule

// ==== dv/tb_fetch_top.sv ====
`include "rv_defines.svh"

module tb_fetch_top;

  timeunit 1ns;
  timeprecision 1ps;

  import fetch_pkg::*;

  localparam int CLK_PERIOD_NS = 40;

  typedef enum logic [1:0] {
    REC_LOAD,
    REC_JUMP,
    REC_RUN,
    REC_EXPECT
  } rec_kind_t;

  // one line of the stimulus file
  // load uses a for word index and b for data
  // jump uses a for target and b for lead cycles
  // run uses a for count
  // expect uses a for pc and b for instr
  typedef struct packed {
    rec_kind_t   kind;
    logic [63:0] a;
    logic [63:0] b;
  } record_t;

  logic       clk;
  logic       arst_n;
  logic       fetch_en_i;
  logic       jump_valid_i;
  pc_t        jump_pc_i;
  logic       load_valid_i;
  ram_load_t  load_i;
  logic       fetch_valid_o;
  fetch_pkt_t fetch_o;

  record_t recs[$];
  int      fetch_total;
  int      limit_ns;
  logic    first_fetch;

  tb_clkgen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) u_clkgen (
    .clk_o    (clk),
    .arst_n_o (arst_n)
  );

  fetch_top DUT (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .fetch_en_i    (fetch_en_i),
    .jump_valid_i  (jump_valid_i),
    .jump_pc_i     (jump_pc_i),
    .load_valid_i  (load_valid_i),
    .load_i        (load_i),
    .fetch_valid_o (fetch_valid_o),
    .fetch_o       (fetch_o)
  );

  task automatic abort_run(input string why);
    $display("%s (at %0t ns)", why, $time);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // parse the whole file up front so the watchdog knows the fetch count
  task automatic read_stimulus();
    int          fd;
    int          n;
    string       word;
    string       rest;
    logic [63:0] a;
    logic [63:0] b;
    record_t     rec;
    fd = $fopen("dv/fetch_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open stimulus file dv/fetch_stimulus.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", word);
      if (n != 1) begin
        break;
      end
      a = '0;
      b = '0;
      if (word[0] == "#") begin
        // skip the rest of a comment line
        n = $fgets(rest, fd);
        continue;
      end else if (word == "load") begin
        rec.kind = REC_LOAD;
        n = $fscanf(fd, "%d %h", a, b);
      end else if (word == "jump") begin
        rec.kind = REC_JUMP;
        n = $fscanf(fd, "%h %d", a, b);
      end else if (word == "run") begin
        rec.kind = REC_RUN;
        n = $fscanf(fd, "%d", a);
        n = n + 1;
      end else if (word == "expect") begin
        rec.kind = REC_EXPECT;
        n = $fscanf(fd, "%h %h", a, b);
        fetch_total++;
      end else begin
        abort_run({"unknown record in stimulus file: ", word});
      end
      if (n != 2) begin
        abort_run({"malformed ", word, " record in stimulus file"});
      end
      rec.a = a;
      rec.b = b;
      recs.push_back(rec);
    end
    $fclose(fd);
  endtask

  // n cycles with no fetch strobe allowed
  task automatic expect_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk);
      check_value(fetch_valid_o, 1'b0, what);
    end
  endtask

  task automatic load_word(input record_t rec);
    load_valid_i = 1'b1;
    load_i.idx   = rec.a[`RAM_AW-1:0];
    load_i.data  = rec.b;
    @(negedge clk);
    load_valid_i = 1'b0;
  endtask

  // lead > 0 puts a read in flight before the strobe
  task automatic apply_jump(input record_t rec);
    if (rec.b != 0) begin
      fetch_en_i = 1'b1;
      expect_quiet(int'(rec.b), "fetch strobe before jump");
    end
    jump_valid_i = 1'b1;
    jump_pc_i    = rec.a;
    @(negedge clk);
    jump_valid_i = 1'b0;
    fetch_en_i   = 1'b0;
    // the stale beat must be swallowed
    if (rec.b != 0) begin
      expect_quiet(10, "stale fetch delivered after jump");
    end
  endtask

  task automatic run_fetches(input int at);
    int          count;
    int          gap;
    int          got;
    logic [63:0] prev_pc;
    record_t     exp_rec;
    count = int'(recs[at].a);
    if (at + count >= recs.size()) begin
      abort_run("run record has fewer expect records than its count");
    end
    gap = $urandom % 4;
    expect_quiet(gap, "fetch strobe between runs");
    fetch_en_i = 1'b1;
    got        = 0;
    prev_pc    = '0;
    while (got < count) begin
      @(negedge clk);
      if (fetch_valid_o) begin
        exp_rec = recs[at + 1 + got];
        if (exp_rec.kind != REC_EXPECT) begin
          abort_run("run record not followed by enough expect records");
        end
        check_value(fetch_o.pc, exp_rec.a, "fetched pc");
        check_value(fetch_o.instr, exp_rec.b, "fetched instr");
        if (got > 0) begin
          check_value(fetch_o.pc, prev_pc + 64'd4, "pc step between fetches");
        end
        if (first_fetch) begin
          check_value(fetch_o.pc, `RESET_PC, "first pc after reset");
          first_fetch = 1'b0;
        end
        prev_pc = exp_rec.a;
        got++;
      end
    end
    // drop enable on the last strobe so no extra read issues
    fetch_en_i = 1'b0;
  endtask

  // watchdog armed once the fetch count is known
  initial begin
    wait (limit_ns != 0);
    #(limit_ns);
    abort_run("timeout waiting for fetch");
  end

  initial begin
    int idx;
    fetch_en_i   = 1'b0;
    jump_valid_i = 1'b0;
    jump_pc_i    = '0;
    load_valid_i = 1'b0;
    load_i       = '0;
    fetch_total  = 0;
    limit_ns     = 0;
    first_fetch  = 1'b1;
    void'($urandom(92031));
    read_stimulus();
    limit_ns = fetch_total * (`RD_WAIT + 8) * CLK_PERIOD_NS + 2000;
    @(posedge arst_n);
    @(posedge clk);
    @(negedge clk);
    expect_quiet(4, "fetch strobe after reset with fetch off");
    idx = 0;
    while (idx < recs.size()) begin
      case (recs[idx].kind)
        REC_LOAD: begin
          load_word(recs[idx]);
          idx++;
        end
        REC_JUMP: begin
          apply_jump(recs[idx]);
          idx++;
        end
        REC_RUN: begin
          run_fetches(idx);
          idx = idx + 1 + int'(recs[idx].a);
        end
        default: begin
          abort_run("expect record outside a run in stimulus file");
        end
      endcase
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

// ==== source/axi_chan_slice.sv ====
module axi_chan_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  // upstream side
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  // downstream side
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  // single entry, either empty or full
  logic     full_q;
  payload_t data_q;

  // accept only when empty, so ready never depends on out_ready_i
  assign in_ready_o  = ~full_q;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i && in_ready_o) begin
      full_q <= 1'b1;
    end else if (out_valid_o && out_ready_i) begin
      // drained, ready again next cycle
      full_q <= 1'b0;
    end
  end

  // payload captured on the input handshake only
  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

endmodule

// ==== source/axi_lite_pkg.sv ====
`include "rv_defines.svh"

package axi_lite_pkg;

  // read address channel payload
  typedef struct packed {
    logic [`XLEN-1:0] addr;
    logic [2:0]       prot;
    logic [2:0]       size;
  } axi_ar_t;

  // read data channel payload
  typedef struct packed {
    logic [`XLEN-1:0] data;
    logic [1:0]       resp;
  } axi_r_t;

  // response codes, only OKAY is ever returned here
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // size code for a 4-byte access
  localparam logic [2:0] SIZE_WORD = 3'b010;

  // prot with the instruction bit set, unprivileged, secure
  localparam logic [2:0] PROT_INSTR = 3'b100;

endpackage

// ==== source/axi_rd_master.sv ====
`include "rv_defines.svh"

module axi_rd_master (
  input  logic                   clk_i,
  input  logic                   arst_n_i,
  input  logic                   fetch_en_i,
  // jump strobe, everything in flight turns stale
  input  logic                   jump_i,
  input  fetch_pkg::pc_t         pc_i,
  // AR channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output axi_lite_pkg::axi_ar_t  ar_o,
  // R channel
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  axi_lite_pkg::axi_r_t   r_i,
  // delivered fetch, one cycle after the R beat
  output logic                   fetch_done_o,
  output fetch_pkg::fetch_pkt_t  fetch_o
);

  import fetch_pkg::*;
  import axi_lite_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    DATA
  } state_t;

  state_t     state_q;
  state_t     state_d;
  pc_t        addr_q;
  logic       discard_q;
  logic       discard_d;
  logic       issue;
  logic       r_hs;
  logic       drop;
  instr_t     instr_sel;
  fetch_pkt_t fetch_q;

  // no stall downstream, R is always taken
  assign r_ready_o = 1'b1;
  assign r_hs      = r_valid_i & r_ready_o;

  // hold off while a jump lands, and while pc_gen has not yet stepped
  assign issue = (state_q == IDLE) & fetch_en_i & ~jump_i & ~fetch_done_o;

  // a jump in the same cycle as the beat also makes it stale
  assign drop = discard_q | jump_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (issue) begin
          state_d = ADDR;
        end
      end
      ADDR: begin
        // payload stays put until the slice takes it
        if (ar_ready_i) begin
          state_d = DATA;
        end
      end
      DATA: begin
        if (r_hs) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  // stale marker for the single outstanding read
  always_comb begin
    discard_d = discard_q;
    if ((state_q == DATA) && r_hs) begin
      discard_d = 1'b0;
    end else if (jump_i && (state_q != IDLE)) begin
      discard_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      discard_q    <= 1'b0;
      fetch_done_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      discard_q    <= discard_d;
      fetch_done_o <= (state_q == DATA) & r_hs & ~drop;
    end
  end

  // issued address, also the pc reported with the instruction
  always_ff @(posedge clk_i) begin
    if (issue) begin
      addr_q <= pc_i;
    end
  end

  // bit 2 picks the half of the 64-bit beat
  assign instr_sel = addr_q[2] ? r_i.data[`XLEN-1:`INST_LEN] : r_i.data[`INST_LEN-1:0];

  always_ff @(posedge clk_i) begin
    if ((state_q == DATA) && r_hs) begin
      fetch_q.pc    <= addr_q;
      fetch_q.instr <= instr_sel;
    end
  end

  assign fetch_o = fetch_q;

  assign ar_valid_o = (state_q == ADDR);
  assign ar_o.addr  = addr_q;
  assign ar_o.prot  = PROT_INSTR;
  assign ar_o.size  = SIZE_WORD;

endmodule

// ==== source/fetch_pkg.sv ====
`include "rv_defines.svh"

package fetch_pkg;

  // fetch address
  typedef logic [`XLEN-1:0] pc_t;

  // raw instruction word
  typedef logic [`INST_LEN-1:0] instr_t;

  // one delivered fetch, pc paired with its instruction
  typedef struct packed {
    pc_t    pc;
    instr_t instr;
  } fetch_pkt_t;

  // ram load beat, word index plus full 64-bit word
  typedef struct packed {
    logic [`RAM_AW-1:0] idx;
    logic [`XLEN-1:0]   data;
  } ram_load_t;

endpackage

// ==== source/fetch_top.sv ====
module fetch_top (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  fetch_en_i,
  // execute-stage jump stand-in
  input  logic                  jump_valid_i,
  input  fetch_pkg::pc_t        jump_pc_i,
  // ram loader
  input  logic                  load_valid_i,
  input  fetch_pkg::ram_load_t  load_i,
  // fetched instruction strobe
  output logic                  fetch_valid_o,
  output fetch_pkg::fetch_pkt_t fetch_o
);

  import fetch_pkg::*;
  import axi_lite_pkg::*;

  pc_t     pc;
  logic    fetch_done;

  // master side of AR and R
  logic    m_ar_valid;
  logic    m_ar_ready;
  axi_ar_t m_ar;
  logic    m_r_valid;
  logic    m_r_ready;
  axi_r_t  m_r;

  // slave side of AR and R
  logic    s_ar_valid;
  logic    s_ar_ready;
  axi_ar_t s_ar;
  logic    s_r_valid;
  logic    s_r_ready;
  axi_r_t  s_r;

  // pc steps on each delivered fetch
  pc_gen u_pc_gen (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .step_i     (fetch_done),
    .redirect_i (jump_valid_i),
    .target_i   (jump_pc_i),
    .pc_o       (pc)
  );

  axi_rd_master u_rd_master (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .fetch_en_i   (fetch_en_i),
    .jump_i       (jump_valid_i),
    .pc_i         (pc),
    .ar_valid_o   (m_ar_valid),
    .ar_ready_i   (m_ar_ready),
    .ar_o         (m_ar),
    .r_valid_i    (m_r_valid),
    .r_ready_o    (m_r_ready),
    .r_i          (m_r),
    .fetch_done_o (fetch_done),
    .fetch_o      (fetch_o)
  );

  // AR stage, master to slave
  axi_chan_slice #(.payload_t(axi_ar_t)) u_ar_slice (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (m_ar_valid),
    .in_ready_o  (m_ar_ready),
    .in_data_i   (m_ar),
    .out_valid_o (s_ar_valid),
    .out_ready_i (s_ar_ready),
    .out_data_o  (s_ar)
  );

  // R stage, slave back to master
  axi_chan_slice #(.payload_t(axi_r_t)) u_r_slice (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (s_r_valid),
    .in_ready_o  (s_r_ready),
    .in_data_i   (s_r),
    .out_valid_o (m_r_valid),
    .out_ready_i (m_r_ready),
    .out_data_o  (m_r)
  );

  instr_ram_slave u_ram (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .load_valid_i (load_valid_i),
    .load_i       (load_i),
    .ar_valid_i   (s_ar_valid),
    .ar_ready_o   (s_ar_ready),
    .ar_i         (s_ar),
    .r_valid_o    (s_r_valid),
    .r_ready_i    (s_r_ready),
    .r_o          (s_r)
  );

  assign fetch_valid_o = fetch_done;

endmodule

// ==== source/instr_ram_slave.sv ====
`include "rv_defines.svh"

module instr_ram_slave (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  // load port, used while fetch is off
  input  logic                  load_valid_i,
  input  fetch_pkg::ram_load_t  load_i,
  // AR channel
  input  logic                  ar_valid_i,
  output logic                  ar_ready_o,
  input  axi_lite_pkg::axi_ar_t ar_i,
  // R channel
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output axi_lite_pkg::axi_r_t  r_o
);

  import axi_lite_pkg::*;

  localparam int unsigned WAIT_W = $clog2(`RD_WAIT + 1);

  logic [`XLEN-1:0]   mem [`RAM_DEPTH];
  logic [`RAM_AW-1:0] ar_idx;
  logic               ar_hs;
  logic               busy_q;
  logic [WAIT_W-1:0]  wait_q;
  logic [`XLEN-1:0]   rdata_q;

  // 8-byte words, upper address bits fold into the depth
  assign ar_idx = ar_i.addr[`RAM_AW+2:3];

  // one read at a time, no new AR until R is gone
  assign ar_ready_o = ~busy_q;
  assign ar_hs      = ar_valid_i & ar_ready_o;

  // loader writes
  always_ff @(posedge clk_i) begin
    if (load_valid_i) begin
      mem[load_i.idx] <= load_i.data;
    end
  end

  // word sampled at AR accept, held until R handshake
  always_ff @(posedge clk_i) begin
    if (ar_hs) begin
      rdata_q <= mem[ar_idx];
    end
  end

  // wait timer
  // loads RD_WAIT-1 so R valid shows RD_WAIT cycles after accept
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q <= 1'b0;
      wait_q <= '0;
    end else if (ar_hs) begin
      busy_q <= 1'b1;
      wait_q <= WAIT_W'(`RD_WAIT - 1);
    end else if (busy_q) begin
      if (wait_q != '0) begin
        wait_q <= wait_q - 1'b1;
      end else if (r_ready_i) begin
        // beat taken, free for the next AR
        busy_q <= 1'b0;
      end
    end
  end

  assign r_valid_o = busy_q & (wait_q == '0);

  // no error path, every read is OKAY
  assign r_o.data = rdata_q;
  assign r_o.resp = RESP_OKAY;

endmodule

// ==== source/pc_gen.sv ====
`include "rv_defines.svh"

module pc_gen (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // fetch delivered, move to the next word
  input  logic           step_i,
  // jump from outside
  input  logic           redirect_i,
  input  fetch_pkg::pc_t target_i,
  output fetch_pkg::pc_t pc_o
);

  import fetch_pkg::*;

  pc_t pc_q;
  pc_t pc_d;

  // redirect beats step when both arrive together
  always_comb begin
    pc_d = pc_q;
    if (redirect_i) begin
      pc_d = target_i;
    end else if (step_i) begin
      // next sequential instruction
      pc_d = pc_q + pc_t'(4);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= `RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // registered pc, new value seen one cycle after step or redirect
  assign pc_o = pc_q;

endmodule

// ==== source/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data path and address width
`define XLEN 64

// one rv instruction
`define INST_LEN 32

// first fetch address after reset
`define RESET_PC 64'h0000_0000_8000_0000

// instruction ram geometry, 64-bit words
`define RAM_DEPTH 64

// word index width, log2 of RAM_DEPTH
`define RAM_AW 6

// slave wait states between AR accept and R valid
`define RD_WAIT 3

`endif

// ==== vlog.f ====
+incdir+source
source/fetch_pkg.sv
source/axi_lite_pkg.sv
source/pc_gen.sv
source/axi_chan_slice.sv
source/axi_rd_master.sv
source/instr_ram_slave.sv
source/fetch_top.sv
dv/tb_clkgen.sv
dv/tb_fetch_top.sv
